//--- verilog/siggen_pkg.sv
// Signal generator shared definitions
package siggen_pkg;

    // Phase counter and waveform period
    localparam int PHASE_BITS = 6;
    localparam int PERIOD     = 1 << PHASE_BITS;     // Steps in one full period

    typedef logic [PHASE_BITS-1:0] phase_t;          // Position within the period

    // DAC levels and control lines
    localparam int LEVELS    = 16;                   // Positive levels and as many negative
    localparam int DAC_LINES = 2 * LEVELS + 1;       // Zero line plus both polarities

    // Line 0 is 0 V, 1..16 positive, 17..32 negative
    typedef logic [DAC_LINES-1:0] dac_code_t;

    typedef logic signed [5:0] level_t;              // -16 .. +16

    // Step modes
    localparam int NUM_MODES = 3;

    typedef enum logic [1:0] {
        STEPS_64 = 2'd0,                             // Full resolution
        STEPS_32 = 2'd1,                             // Every second level
        STEPS_16 = 2'd2                              // Every fourth level
    } step_mode_e;                                   // Code 3 behaves as STEPS_64

    localparam dac_code_t ZERO_CODE = dac_code_t'(1); // Only the 0 V switch closed

    // Reference clock pairs
    typedef struct packed {
        logic i_p;                                   // In-phase clock
        logic i_n;
        logic q_p;                                   // Quadrature clock
        logic q_n;
    } ref_clk_t;

    // One table output per step mode indexed by the mode code
    typedef dac_code_t [NUM_MODES-1:0] table_bus_t;

endpackage

//--- verilog/phase_counter.sv
// Waveform phase counter
`timescale 1ns/100ps

module phase_counter (
    input  logic               Clk,
    input  logic               Resetn,
    output siggen_pkg::phase_t phase
);

    // Free running and wrapping from the last step back to 0
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            phase <= '0;
        end else begin
            phase <= phase + siggen_pkg::phase_t'(1);
        end
    end

endmodule

//--- verilog/triangle_table.sv
// Triangle waveform level decoder
`timescale 1ns/100ps

module triangle_table #(
    parameter int STEP_SHIFT = 0                     // Log2 of the phase stride
) (
    input  siggen_pkg::phase_t    phase,
    output siggen_pkg::dac_code_t dac_code
);

    siggen_pkg::phase_t scaled;                      // Phase after stride scaling
    siggen_pkg::level_t level;                       // Signed triangle level

    // Coarser modes walk the same table with a larger stride
    assign scaled = siggen_pkg::phase_t'(phase << STEP_SHIFT);

    // Fold the period into a triangle
    always_comb begin
        int s;
        s = int'(scaled);
        if (s <= siggen_pkg::LEVELS) begin
            level = siggen_pkg::level_t'(s);         // Rising from 0 V
        end else if (s <= 3 * siggen_pkg::LEVELS) begin
            // Falling through zero down to the negative peak
            level = siggen_pkg::level_t'(2 * siggen_pkg::LEVELS - s);
        end else begin
            level = siggen_pkg::level_t'(s - siggen_pkg::PERIOD); // Back up to 0 V
        end
    end

    // One switch closed per level
    always_comb begin
        int line_idx;
        if (level >= 0) begin
            line_idx = int'(level);                  // Positive lines sit right above 0 V
        end else begin
            line_idx = siggen_pkg::LEVELS - int'(level); // Negative lines start at 17
        end
        dac_code           = '0;
        dac_code[line_idx] = 1'b1;
    end

endmodule

//--- verilog/dac_code_select.sv
// DAC control word select and register
`timescale 1ns/100ps

module dac_code_select (
    input  logic                   Clk,
    input  logic                   Resetn,
    input  logic                   count_enable,
    input  siggen_pkg::step_mode_e step_mode,
    input  siggen_pkg::table_bus_t table_bus,
    output siggen_pkg::dac_code_t  dac_code
);

    siggen_pkg::dac_code_t next_code;                // Selected and gated word

    always_comb begin
        case (step_mode)
            siggen_pkg::STEPS_32: next_code = table_bus[siggen_pkg::STEPS_32];
            siggen_pkg::STEPS_16: next_code = table_bus[siggen_pkg::STEPS_16];
            default:              next_code = table_bus[siggen_pkg::STEPS_64];
        endcase

        // Source parked at 0 V while counting is off
        if (!count_enable) begin
            next_code = siggen_pkg::ZERO_CODE;
        end
    end

    // Registered so the analog switches see a single clean transition
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            dac_code <= siggen_pkg::ZERO_CODE;
        end else begin
            dac_code <= next_code;
        end
    end

endmodule

//--- verilog/iq_clock_gen.sv
// I/Q reference clock generator
`timescale 1ns/100ps

module iq_clock_gen (
    input  logic                   Clk,
    input  logic                   Resetn,
    input  siggen_pkg::phase_t     phase,
    input  siggen_pkg::step_mode_e step_mode,
    output siggen_pkg::ref_clk_t   ref_clk
);

    logic [2:0]         half_bit;                    // Phase bit that toggles each half period
    siggen_pkg::phase_t low_mask;                    // Bits below the half-period bit
    siggen_pkg::phase_t mid_phase;                   // Middle of a half period
    logic               at_mid;
    logic               i_next;
    logic               q_next;

    // Shorter periods use a lower counter bit
    always_comb begin
        case (step_mode)
            siggen_pkg::STEPS_32: half_bit = 3'(siggen_pkg::PHASE_BITS - 2);
            siggen_pkg::STEPS_16: half_bit = 3'(siggen_pkg::PHASE_BITS - 3);
            default:              half_bit = 3'(siggen_pkg::PHASE_BITS - 1);
        endcase
    end

    assign low_mask  = siggen_pkg::phase_t'((1 << half_bit) - 1);
    assign mid_phase = siggen_pkg::phase_t'(1 << (half_bit - 3'd1));
    assign at_mid    = (phase & low_mask) == mid_phase;

    assign i_next = ~phase[half_bit];                // High in the first half period

    /*
     * Sampling I halfway through each half period puts Q a quarter
     * period behind I. Between samples Q simply holds.
     */
    assign q_next = at_mid ? i_next : ref_clk.q_p;

    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            ref_clk <= '0;                           // All pairs low in reset
        end else begin
            ref_clk.i_p <= i_next;
            ref_clk.i_n <= ~i_next;
            ref_clk.q_p <= q_next;
            ref_clk.q_n <= ~q_next;
        end
    end

endmodule

//--- verilog/siggen_top.sv
// Bio-impedance signal source drive
`timescale 1ns/100ps

module siggen_top (
    input  logic                   Clk,
    input  logic                   Resetn,
    input  logic                   count_enable,     // Low holds the 0 V line
    input  siggen_pkg::step_mode_e step_mode,
    output siggen_pkg::dac_code_t  dac_code,
    output siggen_pkg::ref_clk_t   ref_clk
);

    siggen_pkg::phase_t     phase;                   // Shared waveform position
    siggen_pkg::table_bus_t table_bus;               // One table output per mode

    phase_counter phase_counter_inst (
        .Clk    (Clk),
        .Resetn (Resetn),
        .phase  (phase)
    );

    // Table k steps through the period 2^k positions at a time
    generate
        for (genvar k = 0; k < siggen_pkg::NUM_MODES; k++) begin : g_table
            triangle_table #(
                .STEP_SHIFT (k)
            ) triangle_table_inst (
                .phase    (phase),
                .dac_code (table_bus[k])
            );
        end
    endgenerate

    dac_code_select dac_code_select_inst (
        .Clk          (Clk),
        .Resetn       (Resetn),
        .count_enable (count_enable),
        .step_mode    (step_mode),
        .table_bus    (table_bus),
        .dac_code     (dac_code)
    );

    // Runs from the same phase, so I stays aligned to the waveform period
    iq_clock_gen iq_clock_gen_inst (
        .Clk       (Clk),
        .Resetn    (Resetn),
        .phase     (phase),
        .step_mode (step_mode),
        .ref_clk   (ref_clk)
    );

endmodule

//--- bench/tb_siggen.sv
// Signal generator testbench
`timescale 1ns/100ps

module tb_siggen;

    localparam real CLK_PERIOD      = 40.0;          // ns
    localparam int  RESET_CYCLES    = 5;
    localparam int  PERIOD          = 64;            // Phase steps per waveform period
    localparam int  DISABLE_CYCLES  = 16;            // Per mode with counting off
    localparam int  RANDOM_CYCLES   = 400;
    localparam int  LAG_CYCLES      = 3 * PERIOD;    // Upper bound per quarter-lag run
    localparam int  WATCHDOG_MARGIN = 100;

    localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * PERIOD + 3 * PERIOD
                                  + 4 * DISABLE_CYCLES + PERIOD
                                  + 4 * LAG_CYCLES + RANDOM_CYCLES;

    logic                   Clk;
    logic                   Resetn;
    logic                   count_enable;
    siggen_pkg::step_mode_e step_mode;
    siggen_pkg::dac_code_t  dac_code;
    siggen_pkg::ref_clk_t   ref_clk;

    siggen_pkg::phase_t model_phase;                 // Phase the DUT presents next
    logic               model_q;                     // Expected Q level
    logic [31:0]        rand_state;
    int                 checks_done;

    siggen_top siggen_top_inst (
        .Clk          (Clk),
        .Resetn       (Resetn),
        .count_enable (count_enable),
        .step_mode    (step_mode),
        .dac_code     (dac_code),
        .ref_clk      (ref_clk)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) Clk = ~Clk;
    end

    initial begin : watchdog
        #((PLANNED_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("Simulation timed out before all tests finished");
        stop_with_failure();
    end

    // Fatal end of run
    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Stride exponent of a mode code where code 3 runs as 64 steps
    function automatic int effective_mode(logic [1:0] code);
        if (code == 2'd3) begin
            return 0;
        end
        return int'(code);
    endfunction

    function automatic siggen_pkg::level_t fold_level(int s);
        if (s <= 16) begin
            return siggen_pkg::level_t'(s);
        end else if (s <= 32) begin
            return siggen_pkg::level_t'(32 - s);
        end else if (s <= 48) begin
            return siggen_pkg::level_t'(-(s - 32));
        end
        return siggen_pkg::level_t'(-(64 - s));
    endfunction

    function automatic siggen_pkg::dac_code_t line_code(siggen_pkg::level_t lvl);
        int line;
        if (lvl >= 0) begin
            line = int'(lvl);
        end else begin
            line = 16 - int'(lvl);                   // -1 lands on line 17
        end
        return siggen_pkg::dac_code_t'(1) << line;
    endfunction

    function automatic siggen_pkg::dac_code_t expected_code(siggen_pkg::phase_t p,
                                                            logic [1:0] code, logic en);
        int s;
        if (!en) begin
            return siggen_pkg::ZERO_CODE;
        end
        s = (int'(p) * (1 << effective_mode(code))) % 64;
        return line_code(fold_level(s));
    endfunction

    function automatic logic i_value(siggen_pkg::phase_t p, logic [1:0] code);
        int b;
        b = 5 - effective_mode(code);
        return ((int'(p) >> b) & 1) == 0;
    endfunction

    function automatic logic next_q(siggen_pkg::phase_t p, logic [1:0] code, logic q);
        int b;
        b = 5 - effective_mode(code);
        if ((int'(p) % (1 << b)) == (1 << (b - 1))) begin
            return i_value(p, code);                 // Mid half period
        end
        return q;
    endfunction

    function automatic siggen_pkg::ref_clk_t expected_ref_clk(siggen_pkg::phase_t p,
                                                              logic [1:0] code, logic q);
        siggen_pkg::ref_clk_t r;
        r.i_p = i_value(p, code);
        r.i_n = ~r.i_p;
        r.q_p = q;
        r.q_n = ~q;
        return r;
    endfunction

    task automatic check_dac_code(string name, siggen_pkg::dac_code_t expected,
                                  siggen_pkg::dac_code_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_ref_clk(string name, siggen_pkg::ref_clk_t expected,
                                 siggen_pkg::ref_clk_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_lag(string name, int expected, int actual);
        if (actual != expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Compares every rising edge against the model
    initial begin : compare_outputs
        siggen_pkg::phase_t p;
        logic [1:0]         code;
        logic               en;
        forever begin
            @(posedge Clk);
            if (!Resetn) begin
                model_phase = '0;
                model_q     = 1'b0;
                #1;
                check_dac_code("dac_code", siggen_pkg::ZERO_CODE, dac_code);
                check_ref_clk("ref_clk", '0, ref_clk);
            end else begin
                p       = model_phase;               // Inputs stable since the falling edge
                code    = step_mode;
                en      = count_enable;
                model_q = next_q(p, code, model_q);
                #1;
                check_dac_code("dac_code", expected_code(p, code, en), dac_code);
                check_ref_clk("ref_clk", expected_ref_clk(p, code, model_q), ref_clk);
                model_phase = p + siggen_pkg::phase_t'(1);
            end
            checks_done++;
        end
    end

    task automatic drive_inputs(logic [1:0] code, logic en);
        @(negedge Clk);
        step_mode    = siggen_pkg::step_mode_e'(code);
        count_enable = en;
    endtask

    task automatic run_cycles(int n);
        repeat (n) @(negedge Clk);
    endtask

    task automatic apply_reset();
        Resetn = 1'b0;
        repeat (RESET_CYCLES) @(negedge Clk);
        Resetn = 1'b1;
        #1;
        // Still in reset state until the first rising edge
        check_dac_code("dac_code", siggen_pkg::ZERO_CODE, dac_code);
        check_ref_clk("ref_clk", '0, ref_clk);
    endtask

    task automatic check_peaks();
        logic seen_pos;
        logic seen_neg;
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        repeat (2 * PERIOD) begin
            @(negedge Clk);
            seen_pos = seen_pos | dac_code[16];
            seen_neg = seen_neg | dac_code[32];
        end
        if (!seen_pos || !seen_neg) begin
            $display("The 64-step waveform never reached both peak lines 16 and 32");
            stop_with_failure();
        end
    endtask

    // Counts cycles from an I rising edge to the next Q rising edge
    task automatic check_quarter_lag(logic [1:0] code);
        logic prev_i;
        int   lag;
        drive_inputs(code, 1'b1);
        run_cycles(PERIOD);                          // Q settled in the new mode
        prev_i = ref_clk.i_p;
        @(negedge Clk);
        while (!(ref_clk.i_p && !prev_i)) begin
            prev_i = ref_clk.i_p;
            @(negedge Clk);
        end
        lag = 0;
        while (!ref_clk.q_p) begin
            lag++;
            @(negedge Clk);
        end
        check_lag("q_p lag behind i_p", 1 << (4 - effective_mode(code)), lag);
    endtask

    task automatic run_random_changes();
        logic [31:0] r;
        repeat (RANDOM_CYCLES) begin
            @(negedge Clk);
            r = next_random();
            if (r[31:29] == 3'd0) begin
                step_mode = siggen_pkg::step_mode_e'(r[27:26]);
            end
            if (r[24:21] < 4'd2) begin
                count_enable = ~count_enable;
            end
        end
    endtask

    initial begin : stimulus
        Resetn       = 1'b0;
        count_enable = 1'b1;
        step_mode    = siggen_pkg::STEPS_64;
        rand_state   = 32'h8e81ff01;
        checks_done  = 0;

        apply_reset();
        check_peaks();                               // Two full 64-step periods

        for (int code = 1; code < 4; code++) begin
            drive_inputs(2'(code), 1'b1);
            run_cycles(PERIOD - 1);
        end

        for (int code = 0; code < 4; code++) begin
            drive_inputs(2'(code), 1'b0);            // Parked at 0 V
            run_cycles(DISABLE_CYCLES - 1);
        end
        drive_inputs(2'd0, 1'b1);
        run_cycles(PERIOD - 1);

        for (int code = 0; code < 4; code++) begin
            check_quarter_lag(2'(code));
        end

        run_random_changes();
        @(negedge Clk);

        if (checks_done > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("No output comparisons were made");
            $display("Verification failed");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

//--- compile.f
verilog/siggen_pkg.sv
verilog/phase_counter.sv
verilog/triangle_table.sv
verilog/dac_code_select.sv
verilog/iq_clock_gen.sv
verilog/siggen_top.sv
bench/tb_siggen.sv

//--- Makefile
# Verilator simulation of the signal generator
#
# Any variable below can be overridden on the command line,
# for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_siggen
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing -Wno-fatal

BIN := V$(TOP)

.PHONY: sim clean

# Build, run, and decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(BIN)
	$(OBJ_DIR)/$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || \
		{ echo "Pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
